//--- verilog/pipePkg.sv
`default_nettype none

package pipePkg;

    // issue width of the pipeline
    // lane 1 holds the older instruction
    parameter int LANES = 2;

    // access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } memSize_t;

    // control-transfer kind carried down the pipe
    typedef enum logic [1:0] {
        NONE      = 2'd0,
        EXCEPTION = 2'd1,
        ERET      = 2'd2
    } ctlType_t;

    // destination register index
    typedef logic [4:0] regIdx_t;

endpackage

`default_nettype wire

//--- verilog/busPkg.sv
`default_nettype none

package busPkg;

    // data bus payload
    typedef logic [31:0] word_t;

    // one enable per byte lane
    typedef logic [3:0] strobe_t;

    // byte address, the RAM drops the low two bits
    typedef logic [31:0] addr_t;

endpackage

`default_nettype wire

//--- verilog/storeAlign.sv
`timescale 1ns/1ns
`default_nettype none

module storeAlign (
    input  logic [1:0]        addrLow,
    input  pipePkg::memSize_t size,
    input  busPkg::word_t     rawData,
    output busPkg::word_t     data,
    output busPkg::strobe_t   strobe
);

    always_comb begin
        case (size)
            pipePkg::BYTE: begin
                // copy the byte into all four lanes
                data   = {4{rawData[7:0]}};
                strobe = busPkg::strobe_t'(4'b0001) << addrLow;
            end
            pipePkg::HALF: begin
                data   = {2{rawData[15:0]}};
                // bit 0 of the address is ignored for halfwords
                strobe = addrLow[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                data   = rawData;
                strobe = 4'b1111;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/loadExtract.sv
`timescale 1ns/1ns
`default_nettype none

module loadExtract (
    input  busPkg::word_t     word,
    input  logic [1:0]        addrLow,
    input  pipePkg::memSize_t size,
    input  logic              signedLoad,
    output busPkg::word_t     data
);

    busPkg::word_t shifted;
    logic [7:0]    byteSel;
    logic [15:0]   halfSel;

    // little-endian, byte 0 sits in bits 7:0
    assign shifted = word >> {addrLow, 3'b000};
    assign byteSel = shifted[7:0];
    assign halfSel = addrLow[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (size)
            pipePkg::BYTE: begin
                if (signedLoad) begin
                    data = {{24{byteSel[7]}}, byteSel};
                end else begin
                    data = {24'd0, byteSel};
                end
            end
            pipePkg::HALF: begin
                if (signedLoad) begin
                    data = {{16{halfSel[15]}}, halfSel};
                end else begin
                    data = {16'd0, halfSel};
                end
            end
            default: data = word;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/memStage.sv
`timescale 1ns/1ns
`default_nettype none

module memStage (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         inReq,
    input  logic              [pipePkg::LANES-1:0]       laneValid,
    input  logic              [pipePkg::LANES-1:0]       memRead,
    input  logic              [pipePkg::LANES-1:0]       memWrite,
    input  logic              [pipePkg::LANES-1:0]       loadSigned,
    input  logic              [pipePkg::LANES-1:0]       regWrite,
    input  pipePkg::memSize_t [pipePkg::LANES-1:0]       size,
    input  pipePkg::ctlType_t [pipePkg::LANES-1:0]       ctlType,
    input  logic              [pipePkg::LANES-1:0]       tlbExc,
    input  busPkg::addr_t     [pipePkg::LANES-1:0]       addr,
    input  busPkg::word_t     [pipePkg::LANES-1:0]       storeData,
    input  busPkg::word_t     [pipePkg::LANES-1:0]       aluResult,
    input  pipePkg::regIdx_t  [pipePkg::LANES-1:0]       regDst,
    input  logic                                         bundleDone,
    output logic                                         inAck,
    output logic                                         bundleStart,
    output logic              [pipePkg::LANES-1:0]       accessEn,
    output logic              [pipePkg::LANES-1:0]       busWriteLane,
    output busPkg::addr_t     [pipePkg::LANES-1:0]       busAddrLane,
    output busPkg::word_t     [pipePkg::LANES-1:0]       busDataLane,
    output busPkg::strobe_t   [pipePkg::LANES-1:0]       busStrobeLane,
    output logic              [pipePkg::LANES-1:0]       stRegWrite,
    output pipePkg::memSize_t [pipePkg::LANES-1:0]       stSize,
    output logic              [pipePkg::LANES-1:0]       stSigned,
    output pipePkg::regIdx_t  [pipePkg::LANES-1:0]       stDst,
    output busPkg::word_t     [pipePkg::LANES-1:0]       stAlu,
    output logic              [pipePkg::LANES-1:0]       stMemRead,
    output logic                                         excOut
);

    // input handshake phases
    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] BUSY = 2'd1;
    localparam logic [1:0] ACK  = 2'd2;

    logic [1:0] state;
    logic       capture;

    // registered bundle
    logic              [pipePkg::LANES-1:0] validQ;
    logic              [pipePkg::LANES-1:0] readQ;
    logic              [pipePkg::LANES-1:0] writeQ;
    logic              [pipePkg::LANES-1:0] tlbQ;
    logic              [pipePkg::LANES-1:0] regWriteQ;
    pipePkg::ctlType_t [pipePkg::LANES-1:0] ctlQ;
    busPkg::word_t     [pipePkg::LANES-1:0] storeQ;

    logic [pipePkg::LANES-1:0] ownExc;
    logic [pipePkg::LANES-1:0] live;

    assign capture = (state == IDLE) && inReq;
    assign inAck   = (state == ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            bundleStart <= 1'b0;
            validQ      <= '0;
        end else begin
            bundleStart <= capture;
            if (capture) begin
                validQ <= laneValid;
            end
            case (state)
                IDLE:    if (inReq) state <= BUSY;
                BUSY:    if (bundleDone) state <= ACK;
                ACK:     if (!inReq) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            readQ      <= memRead;
            writeQ     <= memWrite;
            tlbQ       <= tlbExc;
            ctlQ       <= ctlType;
            storeQ     <= storeData;
            regWriteQ  <= regWrite;
            stSize     <= size;
            stSigned   <= loadSigned;
            stDst      <= regDst;
            stAlu      <= aluResult;
            busAddrLane <= addr;
        end
    end

    // a lane with its own exception does nothing
    for (genvar i = 0; i < pipePkg::LANES; i++) begin : gLane
        assign ownExc[i] = validQ[i] && (ctlQ[i] == pipePkg::EXCEPTION ||
                                         ctlQ[i] == pipePkg::ERET || tlbQ[i]);

        storeAlign uStoreAlign (
            .addrLow (busAddrLane[i][1:0]),
            .size    (stSize[i]),
            .rawData (storeQ[i]),
            .data    (busDataLane[i]),
            .strobe  (busStrobeLane[i])
        );
    end

    // older lane faulting kills the younger one
    assign live[1] = validQ[1] && !ownExc[1];
    assign live[0] = validQ[0] && !ownExc[0] && !ownExc[1];

    assign accessEn     = live & (readQ | writeQ);
    assign busWriteLane = writeQ;
    assign stMemRead    = readQ;
    assign excOut       = |ownExc;

    // squashed or invalid lanes write nothing back
    assign stRegWrite   = live & regWriteQ;

endmodule

`default_nettype wire

//--- verilog/dbusSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module dbusSequencer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   bundleStart,
    input  logic            [pipePkg::LANES-1:0]   accessEn,
    input  logic            [pipePkg::LANES-1:0]   busWriteLane,
    input  busPkg::addr_t   [pipePkg::LANES-1:0]   busAddrLane,
    input  busPkg::word_t   [pipePkg::LANES-1:0]   busDataLane,
    input  busPkg::strobe_t [pipePkg::LANES-1:0]   busStrobeLane,
    input  logic                                   busAck,
    input  busPkg::word_t                          busRdata,
    output logic                                   busReq,
    output logic                                   busWe,
    output busPkg::addr_t                          busAddr,
    output busPkg::word_t                          busWdata,
    output busPkg::strobe_t                        busStrobe,
    output logic                                   bundleDone,
    output busPkg::word_t   [pipePkg::LANES-1:0]   loadWord
);

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] REQ     = 2'd1;
    localparam logic [1:0] RELEASE = 2'd2;
    localparam logic [1:0] DONE    = 2'd3;

    logic [1:0] state;
    // lane being served
    logic       cur;

    assign busReq     = (state == REQ);
    assign bundleDone = (state == DONE);

    // bus fields follow the current lane
    assign busWe     = busWriteLane[cur];
    assign busAddr   = busAddrLane[cur];
    assign busWdata  = busDataLane[cur];
    assign busStrobe = busStrobeLane[cur];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            cur   <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (bundleStart) begin
                        if (accessEn[1]) begin
                            cur   <= 1'b1;
                            state <= REQ;
                        end else if (accessEn[0]) begin
                            cur   <= 1'b0;
                            state <= REQ;
                        end else begin
                            state <= DONE;
                        end
                    end
                end
                REQ: begin
                    if (busAck) state <= RELEASE;
                end
                RELEASE: begin
                    // wait for the RAM to drop ack
                    if (!busAck) begin
                        if (cur && accessEn[0]) begin
                            cur   <= 1'b0;
                            state <= REQ;
                        end else begin
                            state <= DONE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == REQ && busAck) begin
            loadWord[cur] <= busRdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dataRam.sv
`timescale 1ns/1ns
`default_nettype none

module dataRam #(
    parameter int RAM_WORDS = 256,
    parameter int ACK_DELAY = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            busReq,
    input  logic            busWe,
    input  busPkg::addr_t   busAddr,
    input  busPkg::word_t   busWdata,
    input  busPkg::strobe_t busStrobe,
    output logic            busAck,
    output busPkg::word_t   busRdata
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam int CNT_W = $clog2(ACK_DELAY + 1) + 1;
    localparam logic [CNT_W-1:0] LAST_WAIT = (ACK_DELAY > 0) ? CNT_W'(ACK_DELAY - 1) : '0;

    busPkg::word_t    mem [RAM_WORDS];
    logic [IDX_W-1:0] wordIdx;
    logic [IDX_W-1:0] clearIdx;
    logic [CNT_W-1:0] waitCnt;
    logic             clearing;
    logic             hit;

    assign wordIdx = IDX_W'((busAddr >> 2) % RAM_WORDS);
    // last wait cycle, the access happens here
    assign hit = !clearing && busReq && !busAck && (waitCnt == LAST_WAIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            clearing <= 1'b1;
            clearIdx <= '0;
            waitCnt  <= '0;
            busAck   <= 1'b0;
        end else if (clearing) begin
            // zero sweep, one word per cycle
            if (clearIdx == IDX_W'(RAM_WORDS - 1)) clearing <= 1'b0;
            clearIdx <= clearIdx + 1'b1;
        end else if (busAck) begin
            if (!busReq) busAck <= 1'b0;
        end else if (busReq) begin
            if (hit) begin
                busAck  <= 1'b1;
                waitCnt <= '0;
            end else begin
                waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clearIdx] <= '0;
        end else if (hit) begin
            if (busWe) begin
                for (int b = 0; b < 4; b++) begin
                    if (busStrobe[b]) mem[wordIdx][8*b +: 8] <= busWdata[8*b +: 8];
                end
            end else begin
                busRdata <= mem[wordIdx];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/memSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

module memSubsystem #(
    parameter int RAM_WORDS = 256,
    parameter int ACK_DELAY = 2
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   inReq,
    input  logic              [pipePkg::LANES-1:0] laneValid,
    input  logic              [pipePkg::LANES-1:0] memRead,
    input  logic              [pipePkg::LANES-1:0] memWrite,
    input  logic              [pipePkg::LANES-1:0] loadSigned,
    input  logic              [pipePkg::LANES-1:0] regWrite,
    input  pipePkg::memSize_t [pipePkg::LANES-1:0] size,
    input  pipePkg::ctlType_t [pipePkg::LANES-1:0] ctlType,
    input  logic              [pipePkg::LANES-1:0] tlbExc,
    input  busPkg::addr_t     [pipePkg::LANES-1:0] addr,
    input  busPkg::word_t     [pipePkg::LANES-1:0] storeData,
    input  busPkg::word_t     [pipePkg::LANES-1:0] aluResult,
    input  pipePkg::regIdx_t  [pipePkg::LANES-1:0] regDst,
    output logic                                   inAck,
    output logic                                   wbValid,
    output logic              [pipePkg::LANES-1:0] wbWrite,
    output pipePkg::regIdx_t  [pipePkg::LANES-1:0] wbDst,
    output busPkg::word_t     [pipePkg::LANES-1:0] wbData,
    output logic                                   excOut
);

    logic                                   bundleStart;
    logic                                   bundleDone;
    logic              [pipePkg::LANES-1:0] accessEn;
    logic              [pipePkg::LANES-1:0] busWriteLane;
    busPkg::addr_t     [pipePkg::LANES-1:0] busAddrLane;
    busPkg::word_t     [pipePkg::LANES-1:0] busDataLane;
    busPkg::strobe_t   [pipePkg::LANES-1:0] busStrobeLane;
    pipePkg::memSize_t [pipePkg::LANES-1:0] stSize;
    logic              [pipePkg::LANES-1:0] stSigned;
    busPkg::word_t     [pipePkg::LANES-1:0] stAlu;
    logic              [pipePkg::LANES-1:0] stMemRead;
    busPkg::word_t     [pipePkg::LANES-1:0] loadWord;
    busPkg::word_t     [pipePkg::LANES-1:0] loadData;

    // data bus
    logic            busReq;
    logic            busWe;
    busPkg::addr_t   busAddr;
    busPkg::word_t   busWdata;
    busPkg::strobe_t busStrobe;
    logic            busAck;
    busPkg::word_t   busRdata;

    memStage uMemStage (
        .clk           (clk),
        .rst           (rst),
        .inReq         (inReq),
        .laneValid     (laneValid),
        .memRead       (memRead),
        .memWrite      (memWrite),
        .loadSigned    (loadSigned),
        .regWrite      (regWrite),
        .size          (size),
        .ctlType       (ctlType),
        .tlbExc        (tlbExc),
        .addr          (addr),
        .storeData     (storeData),
        .aluResult     (aluResult),
        .regDst        (regDst),
        .bundleDone    (bundleDone),
        .inAck         (inAck),
        .bundleStart   (bundleStart),
        .accessEn      (accessEn),
        .busWriteLane  (busWriteLane),
        .busAddrLane   (busAddrLane),
        .busDataLane   (busDataLane),
        .busStrobeLane (busStrobeLane),
        .stRegWrite    (wbWrite),
        .stSize        (stSize),
        .stSigned      (stSigned),
        .stDst         (wbDst),
        .stAlu         (stAlu),
        .stMemRead     (stMemRead),
        .excOut        (excOut)
    );

    dbusSequencer uSequencer (
        .clk           (clk),
        .rst           (rst),
        .bundleStart   (bundleStart),
        .accessEn      (accessEn),
        .busWriteLane  (busWriteLane),
        .busAddrLane   (busAddrLane),
        .busDataLane   (busDataLane),
        .busStrobeLane (busStrobeLane),
        .busAck        (busAck),
        .busRdata      (busRdata),
        .busReq        (busReq),
        .busWe         (busWe),
        .busAddr       (busAddr),
        .busWdata      (busWdata),
        .busStrobe     (busStrobe),
        .bundleDone    (bundleDone),
        .loadWord      (loadWord)
    );

    for (genvar i = 0; i < pipePkg::LANES; i++) begin : gWb
        loadExtract uLoadExtract (
            .word       (loadWord[i]),
            .addrLow    (busAddrLane[i][1:0]),
            .size       (stSize[i]),
            .signedLoad (stSigned[i]),
            .data       (loadData[i])
        );

        // loads return memory data, everything else the ALU result
        assign wbData[i] = stMemRead[i] ? loadData[i] : stAlu[i];
    end

    assign wbValid = bundleDone;

    dataRam #(
        .RAM_WORDS (RAM_WORDS),
        .ACK_DELAY (ACK_DELAY)
    ) uDataRam (
        .clk       (clk),
        .rst       (rst),
        .busReq    (busReq),
        .busWe     (busWe),
        .busAddr   (busAddr),
        .busWdata  (busWdata),
        .busStrobe (busStrobe),
        .busAck    (busAck),
        .busRdata  (busRdata)
    );

endmodule

`default_nettype wire

//--- bench/tbMemSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tbMemSubsystem;

    localparam int LANES        = pipePkg::LANES;
    localparam int RAM_WORDS    = 256;
    localparam int ACK_DELAY    = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_BUNDLES  = 240;
    // bundles plus reset plus the RAM clear sweep
    localparam int WATCHDOG_CYCLES = NUM_BUNDLES * (ACK_DELAY + 10) * 2
                                     + RESET_CYCLES + RAM_WORDS + 20;

    logic                          clk;
    logic                          rst;
    logic                          inReq;
    logic              [LANES-1:0] laneValid;
    logic              [LANES-1:0] memRead;
    logic              [LANES-1:0] memWrite;
    logic              [LANES-1:0] loadSigned;
    logic              [LANES-1:0] regWrite;
    pipePkg::memSize_t [LANES-1:0] size;
    pipePkg::ctlType_t [LANES-1:0] ctlType;
    logic              [LANES-1:0] tlbExc;
    busPkg::addr_t     [LANES-1:0] addr;
    busPkg::word_t     [LANES-1:0] storeData;
    busPkg::word_t     [LANES-1:0] aluResult;
    pipePkg::regIdx_t  [LANES-1:0] regDst;
    logic                          inAck;
    logic                          wbValid;
    logic              [LANES-1:0] wbWrite;
    pipePkg::regIdx_t  [LANES-1:0] wbDst;
    busPkg::word_t     [LANES-1:0] wbData;
    logic                          excOut;

    // reference memory, one entry per byte
    logic [7:0] refMem [RAM_WORDS*4];
    int         errorCount;
    int         busCycles;
    logic       reqPrev;
    int         seedDummy;

    memSubsystem #(
        .RAM_WORDS (RAM_WORDS),
        .ACK_DELAY (ACK_DELAY)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .inReq      (inReq),
        .laneValid  (laneValid),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .loadSigned (loadSigned),
        .regWrite   (regWrite),
        .size       (size),
        .ctlType    (ctlType),
        .tlbExc     (tlbExc),
        .addr       (addr),
        .storeData  (storeData),
        .aluResult  (aluResult),
        .regDst     (regDst),
        .inAck      (inAck),
        .wbValid    (wbValid),
        .wbWrite    (wbWrite),
        .wbDst      (wbDst),
        .wbData     (wbData),
        .excOut     (excOut)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // count rising edges of the data bus request
    always @(posedge clk) begin
        if (rst) begin
            reqPrev   <= 1'b0;
            busCycles <= 0;
        end else begin
            reqPrev <= i_dut.busReq;
            if (i_dut.busReq && !reqPrev) busCycles <= busCycles + 1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the bundles did not retire in the expected time");
        $display("errors: %0d", errorCount);
        $display("Finished with errors");
        $finish;
    end

    task automatic checkWord(string name, busPkg::word_t exp, busPkg::word_t act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkDst(string name, pipePkg::regIdx_t exp, pipePkg::regIdx_t act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkBit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            errorCount++;
        end
    endtask

    task automatic checkCount(string name, int exp, int act);
        if (exp != act) begin
            $display("FAIL %0t %s expected %0d got %0d", $time, name, exp, act);
            errorCount++;
        end
    endtask

    function automatic int sizeBytes(pipePkg::memSize_t sz);
        if (sz == pipePkg::BYTE) return 1;
        if (sz == pipePkg::HALF) return 2;
        return 4;
    endfunction

    // RAM wraps at its depth
    function automatic int memIdx(busPkg::addr_t a);
        return int'(a % busPkg::addr_t'(RAM_WORDS * 4));
    endfunction

    task automatic storeModel(busPkg::addr_t a, pipePkg::memSize_t sz, busPkg::word_t d);
        int            n;
        int            b;
        busPkg::addr_t base;
        n    = sizeBytes(sz);
        base = a & ~busPkg::addr_t'(n - 1);
        for (b = 0; b < n; b++) refMem[memIdx(base + b)] = d[8*b +: 8];
    endtask

    // little-endian gather, then sign or zero fill
    function automatic busPkg::word_t loadModel(busPkg::addr_t a, pipePkg::memSize_t sz,
                                                logic sgn);
        int            n;
        int            b;
        busPkg::addr_t base;
        busPkg::word_t w;
        n    = sizeBytes(sz);
        base = a & ~busPkg::addr_t'(n - 1);
        w    = '0;
        for (b = 0; b < n; b++) w[8*b +: 8] = refMem[memIdx(base + b)];
        if (sgn && n < 4 && w[8*n-1]) w = w | (~busPkg::word_t'(0) << (8 * n));
        return w;
    endfunction

    task automatic clearBundle();
        laneValid  = '0;
        memRead    = '0;
        memWrite   = '0;
        loadSigned = '0;
        regWrite   = '0;
        tlbExc     = '0;
        for (int i = 0; i < LANES; i++) begin
            size[i]    = pipePkg::WORD;
            ctlType[i] = pipePkg::NONE;
        end
        addr      = '0;
        storeData = '0;
        aluResult = '0;
        regDst    = '0;
    endtask

    task automatic setLane(int i, logic valid, logic rd, logic wr, logic sgn, logic rw,
                           pipePkg::memSize_t sz, pipePkg::ctlType_t ctl, logic tlb,
                           busPkg::addr_t a, busPkg::word_t d, busPkg::word_t alu,
                           pipePkg::regIdx_t dst);
        laneValid[i]  = valid;
        memRead[i]    = rd;
        memWrite[i]   = wr;
        loadSigned[i] = sgn;
        regWrite[i]   = rw;
        size[i]       = sz;
        ctlType[i]    = ctl;
        tlbExc[i]     = tlb;
        addr[i]       = a;
        storeData[i]  = d;
        aluResult[i]  = alu;
        regDst[i]     = dst;
    endtask

    // runs one bundle through the input handshake and checks the writeback
    task automatic sendBundle();
        logic          [LANES-1:0] exc;
        logic          [LANES-1:0] live;
        logic          [LANES-1:0] acc;
        logic          [LANES-1:0] dataKnown;
        busPkg::word_t             expData [LANES];
        int                        expCycles;
        int                        startCycles;
        int                        i;
        for (i = 0; i < LANES; i++) begin
            exc[i] = laneValid[i] && (ctlType[i] != pipePkg::NONE || tlbExc[i]);
        end
        live[1]   = laneValid[1] && !exc[1];
        live[0]   = laneValid[0] && !exc[0] && !exc[1];
        expCycles = 0;
        // older lane reaches memory first
        for (i = LANES - 1; i >= 0; i--) begin
            acc[i]       = live[i] && (memRead[i] || memWrite[i]);
            dataKnown[i] = 1'b1;
            expData[i]   = aluResult[i];
            if (acc[i]) expCycles++;
            if (acc[i] && memWrite[i]) begin
                storeModel(addr[i], size[i], storeData[i]);
            end else if (acc[i] && memRead[i]) begin
                expData[i] = loadModel(addr[i], size[i], loadSigned[i]);
            end else if (memRead[i]) begin
                dataKnown[i] = 1'b0;
            end
        end
        startCycles = busCycles;
        inReq = 1'b1;
        @(negedge clk);
        while (!wbValid) @(negedge clk);
        for (i = 0; i < LANES; i++) begin
            checkBit($sformatf("wbWrite[%0d]", i), live[i] && regWrite[i], wbWrite[i]);
            checkDst($sformatf("wbDst[%0d]", i), regDst[i], wbDst[i]);
            if (dataKnown[i]) checkWord($sformatf("wbData[%0d]", i), expData[i], wbData[i]);
        end
        checkBit("excOut", |exc, excOut);
        checkCount("bus accesses", expCycles, busCycles - startCycles);
        @(negedge clk);
        checkBit("wbValid", 1'b0, wbValid);
        checkBit("inAck", 1'b1, inAck);
        while (!inAck) @(negedge clk);
        inReq = 1'b0;
        @(negedge clk);
        while (inAck) @(negedge clk);
    endtask

    task automatic testStoreLoadSameWord();
        clearBundle();
        setLane(1, 1, 0, 1, 0, 0, pipePkg::WORD, pipePkg::NONE, 0, 32'h100, $urandom,
                $urandom, 5'd3);
        setLane(0, 1, 1, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 32'h100, 0, $urandom, 5'd7);
        sendBundle();
    endtask

    task automatic testSubWord();
        int            off;
        busPkg::word_t d;
        for (off = 0; off < 4; off++) begin
            // even offsets get a negative byte
            d = $urandom & 32'hffff_ff7f;
            if (off % 2 == 0) d = d | 32'h80;
            clearBundle();
            setLane(1, 1, 0, 1, 0, 0, pipePkg::BYTE, pipePkg::NONE, 0, 32'h140 + off, d, 0, 0);
            setLane(0, 1, 1, 0, 1, 1, pipePkg::BYTE, pipePkg::NONE, 0, 32'h140 + off, 0, 0, 8);
            sendBundle();
            clearBundle();
            setLane(1, 1, 1, 0, 0, 1, pipePkg::BYTE, pipePkg::NONE, 0, 32'h140 + off, 0, 0, 9);
            setLane(0, 1, 1, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 32'h140, 0, 0, 10);
            sendBundle();
        end
        for (off = 0; off < 4; off += 2) begin
            d = $urandom & 32'hffff_7fff;
            if (off == 0) d = d | 32'h8000;
            clearBundle();
            setLane(1, 1, 0, 1, 0, 0, pipePkg::HALF, pipePkg::NONE, 0, 32'h150 + off, d, 0, 0);
            setLane(0, 1, 1, 0, 1, 1, pipePkg::HALF, pipePkg::NONE, 0, 32'h150 + off, 0, 0, 12);
            sendBundle();
            clearBundle();
            setLane(1, 1, 1, 0, 0, 1, pipePkg::HALF, pipePkg::NONE, 0, 32'h150 + off, 0, 0, 13);
            setLane(0, 1, 1, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 32'h150, 0, 0, 14);
            sendBundle();
        end
    endtask

    task automatic testLaneOneControl();
        pipePkg::ctlType_t ctl;
        int                k;
        clearBundle();
        setLane(1, 1, 0, 1, 0, 0, pipePkg::WORD, pipePkg::NONE, 0, 32'h180, $urandom, 0, 0);
        sendBundle();
        for (k = 0; k < 2; k++) begin
            ctl = (k == 0) ? pipePkg::EXCEPTION : pipePkg::ERET;
            clearBundle();
            // both lanes ask for writeback, neither may get it
            setLane(1, 1, 0, 0, 0, 1, pipePkg::WORD, ctl, 0, 0, 0, $urandom, 0);
            setLane(0, 1, 0, 1, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 32'h180, $urandom, 0, 0);
            sendBundle();
            clearBundle();
            setLane(1, 1, 1, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 32'h180, 0, 0, 11);
            sendBundle();
        end
    endtask

    task automatic testTlbFault();
        int k;
        for (k = 0; k < LANES; k++) begin
            clearBundle();
            setLane(1, 1, 0, 1, 0, 0, pipePkg::WORD, pipePkg::NONE, k == 1, 32'h1a0, $urandom,
                    0, 0);
            setLane(0, 1, 0, 1, 0, 0, pipePkg::WORD, pipePkg::NONE, k == 0, 32'h1a4, $urandom,
                    0, 0);
            sendBundle();
            clearBundle();
            setLane(1, 1, 1, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 32'h1a0, 0, 0, 15);
            setLane(0, 1, 1, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 32'h1a4, 0, 0, 16);
            sendBundle();
        end
    endtask

    task automatic testNoMemory();
        clearBundle();
        setLane(1, 1, 0, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 0, 0, $urandom, 17);
        setLane(0, 1, 0, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 0, 0, $urandom, 18);
        sendBundle();
        clearBundle();
        setLane(1, 1, 0, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 0, 0, $urandom, 19);
        // invalid lane with its write flag set
        setLane(0, 0, 0, 0, 0, 1, pipePkg::WORD, pipePkg::NONE, 0, 0, 0, $urandom, 20);
        sendBundle();
        clearBundle();
        sendBundle();
    endtask

    task automatic testRandom();
        int                n;
        int                i;
        int                op;
        int                r;
        logic              valid;
        pipePkg::memSize_t sz;
        pipePkg::ctlType_t ctl;
        busPkg::addr_t     a;
        for (n = 0; n < 200; n++) begin
            clearBundle();
            for (i = 0; i < LANES; i++) begin
                op    = $urandom % 3;
                sz    = pipePkg::memSize_t'($urandom % 3);
                a     = 32'h200 + ($urandom % 64);
                a     = a & ~busPkg::addr_t'(sizeBytes(sz) - 1);
                r     = $urandom % 16;
                ctl   = (r == 0) ? pipePkg::EXCEPTION : (r == 1) ? pipePkg::ERET : pipePkg::NONE;
                valid = ($urandom % 8) != 0;
                setLane(i, valid, op == 1, op == 2, ($urandom % 2) == 1,
                        valid && (op == 1 || (op == 0 && ($urandom % 2) == 1)), sz, ctl,
                        ($urandom % 8) == 0, a, $urandom, $urandom,
                        pipePkg::regIdx_t'($urandom % 32));
            end
            sendBundle();
        end
    endtask

    initial begin
        seedDummy  = $urandom(32'h2356);
        errorCount = 0;
        for (int j = 0; j < RAM_WORDS * 4; j++) refMem[j] = 8'h00;
        rst   = 1'b1;
        inReq = 1'b0;
        clearBundle();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        checkBit("inAck", 1'b0, inAck);
        checkBit("wbValid", 1'b0, wbValid);
        checkBit("excOut", 1'b0, excOut);
        checkBit("busReq", 1'b0, i_dut.busReq);
        testStoreLoadSameWord();
        testSubWord();
        testLaneOneControl();
        testTlbFault();
        testNoMemory();
        testRandom();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- memSubsystem.f
verilog/pipePkg.sv
verilog/busPkg.sv
verilog/storeAlign.sv
verilog/loadExtract.sv
verilog/memStage.sv
verilog/dbusSequencer.sv
verilog/dataRam.sv
verilog/memSubsystem.sv
bench/tbMemSubsystem.sv

//--- run.sh
#!/bin/sh
# build and run the memSubsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tbMemSubsystem -f memSubsystem.f
./obj_dir/VtbMemSubsystem > sim.log 2>&1
cat sim.log
grep -q "Finished with no errors" sim.log
